//--- hdl/cr_cfg.svh
// Offsets are byte offsets on 16-bit addresses; KBD_FIFO_DEPTH must be a power of two, 2 to 16
`ifndef CR_CFG_SVH
`define CR_CFG_SVH

// ----------------------------------------
// Register map offsets
// ----------------------------------------

// Seven-segment raw bytes, read/write
`define CR_SEG7_0         16'h0000
`define CR_SEG7_1         16'h0004
`define CR_SEG7_2         16'h0008
`define CR_SEG7_3         16'h000C
`define CR_SEG7_4         16'h0010
`define CR_SEG7_5         16'h0014

// LED bank, read/write
`define CR_LED            16'h0018

// Keyboard scan enable, bit 0 only
`define CR_KBD_SCANF_EN   16'h001C

// Board inputs, read only
`define CR_BUTTON_0       16'h0020
`define CR_BUTTON_1       16'h0024
`define CR_SWITCH         16'h0028
`define CR_JOYSTICK_X     16'h002C
`define CR_JOYSTICK_Y     16'h0030

// Keyboard status and data, read only
// A core read of data pops the FIFO
`define CR_KBD_READY      16'h0034
`define CR_KBD_DATA       16'h0038

// ----------------------------------------
// Keyboard FIFO and pipeline constants
// ----------------------------------------
`define KBD_FIFO_DEPTH    4

// Flops between board pins and the read mux
`define CR_IN_SYNC_STAGES 2

// Flops between the register and the board outputs
`define CR_OUT_STAGES     2

`endif

//--- hdl/cr_pkg.sv
// Types only; struct field order fixes the bit layout seen at the cr_top board ports
package cr_pkg;

    // ----------------------------------------
    // Width typedefs
    // ----------------------------------------

    // Data word on core and fabric ports
    typedef logic [31:0] cr_word_t;

    // Register byte offset
    typedef logic [15:0] cr_addr_t;

    // Raw segment pattern, one byte per digit
    typedef logic [7:0] seg7_t;

    typedef logic [9:0] led_t;
    typedef logic [9:0] switch_t;

    // Joystick axis sample from the board ADC
    typedef logic [11:0] joy_t;

    // Keyboard scan code
    typedef logic [7:0] scan_code_t;

    // ----------------------------------------
    // Board structs
    // ----------------------------------------

    // Board inputs, 36 bits, asynchronous to Clk
    typedef struct packed {
        logic    button_0;
        logic    button_1;
        switch_t switch;
        joy_t    joystick_x;
        joy_t    joystick_y;
    } fpga_in_t;

    // Board outputs, 58 bits
    typedef struct packed {
        seg7_t seg7_0;
        seg7_t seg7_1;
        seg7_t seg7_2;
        seg7_t seg7_3;
        seg7_t seg7_4;
        seg7_t seg7_5;
        led_t  led;
    } fpga_out_t;

    // ----------------------------------------
    // Keyboard structs
    // ----------------------------------------

    // FIFO view toward the register map
    // kbd_data valid only while kbd_ready
    typedef struct packed {
        logic       kbd_ready;
        scan_code_t kbd_data;
    } kbd_rd_t;

    // Register map control toward the FIFO
    typedef struct packed {
        logic kbd_pop;
        logic kbd_scanf_en;
    } kbd_ctrl_t;

endpackage

//--- hdl/kbd_fifo.sv
// KBD_FIFO_DEPTH must be a power of two from 2 to 16; pushes while disabled or full are lost
`timescale 1ns/10ps

`include "cr_cfg.svh"

module kbd_fifo
    import cr_pkg::*;
(
    input  logic       Clk,
    input  logic       rst_n,

    // Keyboard side, one-cycle strobe per code
    input  scan_code_t scan_code,
    input  logic       scan_valid,

    // Register map side
    input  kbd_ctrl_t  kbd_ctrl,
    output kbd_rd_t    kbd_rd
);

    localparam int DEPTH = `KBD_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    // One extra bit so a full FIFO is distinct from empty
    localparam int CNT_W = PTR_W + 1;

    scan_code_t       mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    logic full;
    logic empty;
    logic push;
    logic pop;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Gated by the scan enable and free space
    assign push = scan_valid && kbd_ctrl.kbd_scanf_en && !full;
    assign pop  = kbd_ctrl.kbd_pop && !empty;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge Clk) begin
        if (push) begin
            mem[wr_ptr] <= scan_code;
        end
    end

    // ----------------------------------------
    // Pointers and count
    // ----------------------------------------

    // Pointers wrap on their own width
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                // Both or neither leave the count alone
                default: ;
            endcase
        end
    end

    // Head entry, zero while empty
    assign kbd_rd.kbd_ready = !empty;
    assign kbd_rd.kbd_data  = empty ? '0 : mem[rd_ptr];

endmodule

//--- hdl/cr_mem.sv
// Core must not assert wren and rden together; fabric port is read only and never pops the FIFO
`timescale 1ns/10ps

`include "cr_cfg.svh"

module cr_mem
    import cr_pkg::*;
(
    input  logic      Clk,
    input  logic      rst_n,

    // Core port
    input  cr_addr_t  address,
    input  cr_word_t  data,
    input  logic      wren,
    input  logic      rden,
    output cr_word_t  q,

    // Fabric port, read only
    input  cr_addr_t  address_b,
    output cr_word_t  q_b,

    // Board pins
    input  fpga_in_t  fpga_in,
    output fpga_out_t fpga_out,

    // Keyboard FIFO
    input  kbd_rd_t   kbd_rd,
    output kbd_ctrl_t kbd_ctrl
);

    // Read/write registers as the core last wrote them
    fpga_out_t out_reg;
    logic      scanf_en;

    // Board side pipelines
    fpga_in_t  in_sync  [`CR_IN_SYNC_STAGES];
    fpga_out_t out_pipe [`CR_OUT_STAGES];

    // ----------------------------------------
    // Read mux shared by both ports
    // ----------------------------------------

    // Each field zero-extended to the word
    // Unmapped offsets read zero
    function automatic cr_word_t read_reg(
        input cr_addr_t  addr,
        input fpga_out_t rw,
        input logic      scanf,
        input fpga_in_t  ro,
        input kbd_rd_t   kbd
    );
        cr_word_t val;
        val = '0;
        case (addr)
            // Read/write
            `CR_SEG7_0:       val = {24'b0, rw.seg7_0};
            `CR_SEG7_1:       val = {24'b0, rw.seg7_1};
            `CR_SEG7_2:       val = {24'b0, rw.seg7_2};
            `CR_SEG7_3:       val = {24'b0, rw.seg7_3};
            `CR_SEG7_4:       val = {24'b0, rw.seg7_4};
            `CR_SEG7_5:       val = {24'b0, rw.seg7_5};
            `CR_LED:          val = {22'b0, rw.led};
            `CR_KBD_SCANF_EN: val = {31'b0, scanf};
            // Read only, synchronized board inputs
            `CR_BUTTON_0:     val = {31'b0, ro.button_0};
            `CR_BUTTON_1:     val = {31'b0, ro.button_1};
            `CR_SWITCH:       val = {22'b0, ro.switch};
            `CR_JOYSTICK_X:   val = {20'b0, ro.joystick_x};
            `CR_JOYSTICK_Y:   val = {20'b0, ro.joystick_y};
            // Read only, straight from the FIFO
            `CR_KBD_READY:    val = {31'b0, kbd.kbd_ready};
            `CR_KBD_DATA:     val = {24'b0, kbd.kbd_data};
            default:          val = '0;
        endcase
        return val;
    endfunction

    // ----------------------------------------
    // Core write decode
    // ----------------------------------------

    // Only the low bits of each field are kept
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            out_reg  <= '0;
            scanf_en <= 1'b0;
        end else if (wren) begin
            case (address)
                `CR_SEG7_0:       out_reg.seg7_0 <= data[7:0];
                `CR_SEG7_1:       out_reg.seg7_1 <= data[7:0];
                `CR_SEG7_2:       out_reg.seg7_2 <= data[7:0];
                `CR_SEG7_3:       out_reg.seg7_3 <= data[7:0];
                `CR_SEG7_4:       out_reg.seg7_4 <= data[7:0];
                `CR_SEG7_5:       out_reg.seg7_5 <= data[7:0];
                `CR_LED:          out_reg.led    <= data[9:0];
                `CR_KBD_SCANF_EN: scanf_en       <= data[0];
                // Read-only and unmapped offsets drop the write
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // Board input synchronizer
    // ----------------------------------------

    // Pins -> stage 0 -> last stage -> read mux
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CR_IN_SYNC_STAGES; i++) begin
                in_sync[i] <= '0;
            end
        end else begin
            in_sync[0] <= fpga_in;
            for (int i = 1; i < `CR_IN_SYNC_STAGES; i++) begin
                in_sync[i] <= in_sync[i-1];
            end
        end
    end

    // ----------------------------------------
    // Board output staging
    // ----------------------------------------

    // Register -> stage 0 -> last stage -> pins
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CR_OUT_STAGES; i++) begin
                out_pipe[i] <= '0;
            end
        end else begin
            out_pipe[0] <= out_reg;
            for (int i = 1; i < `CR_OUT_STAGES; i++) begin
                out_pipe[i] <= out_pipe[i-1];
            end
        end
    end

    assign fpga_out = out_pipe[`CR_OUT_STAGES-1];

    // ----------------------------------------
    // Registered read ports
    // ----------------------------------------

    // Core q returns to zero when rden drops
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            q <= '0;
        end else if (rden) begin
            q <= read_reg(address, out_reg, scanf_en,
                          in_sync[`CR_IN_SYNC_STAGES-1], kbd_rd);
        end else begin
            q <= '0;
        end
    end

    // Fabric port samples every cycle
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            q_b <= '0;
        end else begin
            q_b <= read_reg(address_b, out_reg, scanf_en,
                            in_sync[`CR_IN_SYNC_STAGES-1], kbd_rd);
        end
    end

    // ----------------------------------------
    // Keyboard control
    // ----------------------------------------

    // Pop in the same cycle as the core read
    // q captures the head before the FIFO drops it
    assign kbd_ctrl.kbd_pop      = rden && (address == `CR_KBD_DATA) && kbd_rd.kbd_ready;
    assign kbd_ctrl.kbd_scanf_en = scanf_en;

endmodule

//--- hdl/cr_top.sv
// fpga_in is asynchronous to Clk; the core must not assert wren and rden in the same cycle
`timescale 1ns/10ps

module cr_top
    import cr_pkg::*;
(
    input  logic       Clk,
    input  logic       rst_n,

    // Core port
    input  cr_addr_t   address,
    input  cr_word_t   data,
    input  logic       wren,
    input  logic       rden,
    output cr_word_t   q,

    // Fabric read port
    input  cr_addr_t   address_b,
    output cr_word_t   q_b,

    // Board pins
    input  fpga_in_t   fpga_in,
    output fpga_out_t  fpga_out,

    // Keyboard
    input  scan_code_t scan_code,
    input  logic       scan_valid,
    output logic       kbd_scanf_en
);

    // ----------------------------------------
    // Register map to FIFO wiring
    // ----------------------------------------
    kbd_ctrl_t kbd_ctrl;
    kbd_rd_t   kbd_rd;

    // Enable bit also goes back out to the keyboard
    assign kbd_scanf_en = kbd_ctrl.kbd_scanf_en;

    // Control registers and both read ports
    cr_mem u_cr_mem (
        .Clk       (Clk),
        .rst_n     (rst_n),
        .address   (address),
        .data      (data),
        .wren      (wren),
        .rden      (rden),
        .q         (q),
        .address_b (address_b),
        .q_b       (q_b),
        .fpga_in   (fpga_in),
        .fpga_out  (fpga_out),
        .kbd_rd    (kbd_rd),
        .kbd_ctrl  (kbd_ctrl)
    );

    // Scan-code buffer
    kbd_fifo u_kbd_fifo (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .scan_code  (scan_code),
        .scan_valid (scan_valid),
        .kbd_ctrl   (kbd_ctrl),
        .kbd_rd     (kbd_rd)
    );

endmodule

//--- test/tb_cr_top.sv
// Needs KBD_FIFO_DEPTH of at least 4 for the keyboard tests; the run stops at 3000 cycles
`timescale 1ns/10ps

`include "cr_cfg.svh"

module tb_cr_top
    import cr_pkg::*;
();

    localparam int MAX_CYCLES = 3000;

    logic       Clk;
    logic       rst_n;
    cr_addr_t   address;
    cr_word_t   data;
    logic       wren;
    logic       rden;
    cr_word_t   q;
    cr_addr_t   address_b;
    cr_word_t   q_b;
    fpga_in_t   fpga_in;
    fpga_out_t  fpga_out;
    scan_code_t scan_code;
    logic       scan_valid;
    logic       kbd_scanf_en;

    // ----------------------------------------
    // Reference model state
    // ----------------------------------------
    // Read/write registers by word index, already masked
    cr_word_t   rw_model [8];
    // Board inputs as seen behind the synchronizer
    fpga_in_t   m_in;
    // Scan codes accepted by the FIFO, head first
    scan_code_t kq [$];

    cr_addr_t unmapped [5] = '{16'h003C, 16'h0040, 16'h0102, 16'h0006, 16'hFFFC};

    // Pending read checks, one writer per variable
    cr_word_t exp_q;
    cr_word_t exp_q_b;
    cr_addr_t q_addr;
    cr_addr_t qb_addr;
    int       q_seq;
    int       qb_seq;
    int       q_seen;
    int       qb_seen;

    int     checks;
    int     errors;
    int     cmp_checks;
    int     cmp_errors;
    int     base_errors;
    int     test_num;
    int     cycles;
    integer seed;

    cr_top u_dut (
        .Clk          (Clk),
        .rst_n        (rst_n),
        .address      (address),
        .data         (data),
        .wren         (wren),
        .rden         (rden),
        .q            (q),
        .address_b    (address_b),
        .q_b          (q_b),
        .fpga_in      (fpga_in),
        .fpga_out     (fpga_out),
        .scan_code    (scan_code),
        .scan_valid   (scan_valid),
        .kbd_scanf_en (kbd_scanf_en)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    // Hard stop, roughly four times the test length
    always @(posedge Clk) begin
        cycles = cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Reference functions
    // ----------------------------------------

    // Expected read value, fields zero-extended
    function automatic cr_word_t cr_expect(input cr_addr_t addr);
        cr_word_t val;
        case (addr)
            `CR_SEG7_0, `CR_SEG7_1, `CR_SEG7_2, `CR_SEG7_3, `CR_SEG7_4, `CR_SEG7_5,
            `CR_LED, `CR_KBD_SCANF_EN: val = rw_model[addr[4:2]];
            `CR_BUTTON_0:   val = {31'b0, m_in.button_0};
            `CR_BUTTON_1:   val = {31'b0, m_in.button_1};
            `CR_SWITCH:     val = {22'b0, m_in.switch};
            `CR_JOYSTICK_X: val = {20'b0, m_in.joystick_x};
            `CR_JOYSTICK_Y: val = {20'b0, m_in.joystick_y};
            `CR_KBD_READY:  val = {31'b0, kq.size() != 0};
            // Head entry, zero while empty
            `CR_KBD_DATA:   val = (kq.size() != 0) ? {24'b0, kq[0]} : '0;
            default:        val = '0;
        endcase
        return val;
    endfunction

    function automatic fpga_out_t expect_out();
        return {rw_model[0][7:0], rw_model[1][7:0], rw_model[2][7:0],
                rw_model[3][7:0], rw_model[4][7:0], rw_model[5][7:0],
                rw_model[6][9:0]};
    endfunction

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------
    task automatic check_outputs();
        @(negedge Clk);
        checks += 2;
        assert (fpga_out === expect_out()) else begin
            $display("mismatch fpga_out: expected %h, got %h", expect_out(), fpga_out);
            errors++;
        end
        assert (kbd_scanf_en === rw_model[7][0]) else begin
            $display("mismatch kbd_scanf_en: expected %h, got %h", rw_model[7][0],
                     kbd_scanf_en);
            errors++;
        end
    endtask

    task automatic core_write(input cr_addr_t addr, input cr_word_t val);
        fpga_out_t prev_out;
        @(posedge Clk);
        address <= addr;
        data    <= val;
        wren    <= 1'b1;
        @(posedge Clk);
        wren <= 1'b0;
        prev_out = expect_out();
        case (addr)
            `CR_SEG7_0, `CR_SEG7_1, `CR_SEG7_2, `CR_SEG7_3, `CR_SEG7_4,
            `CR_SEG7_5:       rw_model[addr[4:2]] = val & 32'h0000_00FF;
            `CR_LED:          rw_model[6] = val & 32'h0000_03FF;
            `CR_KBD_SCANF_EN: rw_model[7] = val & 32'h0000_0001;
            default: ;
        endcase
        // One edge after the write the pins still show the old value
        @(posedge Clk);
        @(negedge Clk);
        checks++;
        assert (fpga_out === prev_out) else begin
            $display("mismatch fpga_out: expected %h, got %h", prev_out, fpga_out);
            errors++;
        end
        // Output pins follow two edges later
        @(posedge Clk);
        check_outputs();
    endtask

    // Pops the model queue on a data read with codes waiting
    task automatic core_read(input cr_addr_t addr);
        @(posedge Clk);
        address <= addr;
        rden    <= 1'b1;
        @(posedge Clk);
        rden   <= 1'b0;
        exp_q  = cr_expect(addr);
        q_addr = addr;
        q_seq++;
        if (addr == `CR_KBD_DATA && kq.size() != 0) begin
            void'(kq.pop_front());
        end
    endtask

    task automatic fabric_read(input cr_addr_t addr);
        @(posedge Clk);
        address_b <= addr;
        @(posedge Clk);
        exp_q_b = cr_expect(addr);
        qb_addr = addr;
        qb_seq++;
    endtask

    task automatic read_both(input cr_addr_t addr);
        core_read(addr);
        fabric_read(addr);
    endtask

    task automatic key_push(input scan_code_t code);
        @(posedge Clk);
        scan_code  <= code;
        scan_valid <= 1'b1;
        @(posedge Clk);
        scan_valid <= 1'b0;
        if (rw_model[7][0] && kq.size() < `KBD_FIFO_DEPTH) begin
            kq.push_back(code);
        end
    endtask

    // Model sees the value once the synchronizer has it
    task automatic hold_inputs(input fpga_in_t val);
        @(posedge Clk);
        fpga_in <= val;
        repeat (2) @(posedge Clk);
        m_in = val;
    endtask

    task automatic end_test(input string name);
        int now_errors;
        repeat (2) @(negedge Clk);
        now_errors = errors + cmp_errors;
        test_num++;
        $display("test %0d %s: %s", test_num, name,
                 (now_errors == base_errors) ? "ok" : "has errors");
        base_errors = now_errors;
    endtask

    // ----------------------------------------
    // Compare process
    // ----------------------------------------
    always @(negedge Clk) begin
        if (q_seq != q_seen) begin
            q_seen = q_seq;
            cmp_checks++;
            assert (q === exp_q) else begin
                $display("mismatch q at %h: expected %h, got %h", q_addr, exp_q, q);
                cmp_errors++;
            end
        end else begin
            // Core port reads back zero between reads
            cmp_checks++;
            assert (q === '0) else begin
                $display("mismatch q idle: expected %h, got %h", 32'h0, q);
                cmp_errors++;
            end
        end
        if (qb_seq != qb_seen) begin
            qb_seen = qb_seq;
            cmp_checks++;
            assert (q_b === exp_q_b) else begin
                $display("mismatch q_b at %h: expected %h, got %h", qb_addr, exp_q_b, q_b);
                cmp_errors++;
            end
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        cr_addr_t a;
        cr_word_t r0;
        cr_word_t r1;
        int       n;
        seed       = 32'h74ae;
        rst_n      = 1'b0;
        address    = '0;
        data       = '0;
        wren       = 1'b0;
        rden       = 1'b0;
        address_b  = '0;
        fpga_in    = '0;
        scan_code  = '0;
        scan_valid = 1'b0;
        m_in       = '0;
        for (n = 0; n < 8; n++) begin
            rw_model[n] = '0;
        end
        repeat (10) @(posedge Clk);
        rst_n <= 1'b1;

        // Everything clear after reset
        check_outputs();
        for (a = 16'h0000; a <= 16'h0038; a = a + 16'h0004) begin
            read_both(a);
        end
        end_test("reset values");

        // Random word index 0 to 7 covers segments, LEDs and scan enable
        for (n = 0; n < 24; n++) begin
            r0 = $random(seed);
            r1 = $random(seed);
            a  = {11'b0, r0[2:0], 2'b00};
            core_write(a, r1);
            read_both(a);
        end
        end_test("register write and read back");

        for (n = 0; n < 5; n++) begin
            r0 = $random(seed);
            core_write(unmapped[n], r0);
        end
        for (a = 16'h0000; a <= 16'h001C; a = a + 16'h0004) begin
            read_both(a);
        end
        for (n = 0; n < 5; n++) begin
            read_both(unmapped[n]);
        end
        end_test("unmapped offsets");

        for (n = 0; n < 16; n++) begin
            r0 = $random(seed);
            r1 = $random(seed);
            hold_inputs({r0[3:0], r1});
            for (a = `CR_BUTTON_0; a <= `CR_JOYSTICK_Y; a = a + 16'h0004) begin
                read_both(a);
            end
        end
        end_test("board inputs");

        core_write(`CR_KBD_SCANF_EN, 32'h0000_0001);
        read_both(`CR_KBD_READY);
        core_read(`CR_KBD_DATA);
        for (n = 0; n < 3; n++) begin
            r0 = $random(seed);
            key_push(r0[7:0]);
        end
        read_both(`CR_KBD_READY);
        // Fabric reads leave the head in place
        fabric_read(`CR_KBD_DATA);
        fabric_read(`CR_KBD_DATA);
        for (n = 0; n < 3; n++) begin
            read_both(`CR_KBD_DATA);
        end
        read_both(`CR_KBD_READY);
        core_read(`CR_KBD_DATA);
        end_test("keyboard push and pop");

        core_write(`CR_KBD_SCANF_EN, 32'h0000_0000);
        for (n = 0; n < 2; n++) begin
            r0 = $random(seed);
            key_push(r0[7:0]);
        end
        read_both(`CR_KBD_READY);
        // Bit 0 only, upper bits dropped
        core_write(`CR_KBD_SCANF_EN, 32'h0000_0003);
        for (n = 0; n < `KBD_FIFO_DEPTH + 2; n++) begin
            r0 = $random(seed);
            key_push(r0[7:0]);
        end
        read_both(`CR_KBD_READY);
        for (n = 0; n < `KBD_FIFO_DEPTH + 1; n++) begin
            core_read(`CR_KBD_DATA);
        end
        read_both(`CR_KBD_READY);
        end_test("dropped pushes");

        $display("checks %0d, errors %0d", checks + cmp_checks, errors + cmp_errors);
        if (errors + cmp_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+hdl
hdl/cr_pkg.sv
hdl/kbd_fifo.sv
hdl/cr_mem.sv
hdl/cr_top.sv
test/tb_cr_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run tb_cr_top under Verilator, then scan the log for the fail message

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_cr_top -f build.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit 1
fi

./obj_dir/Vtb_cr_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi

exit 0
